/* dv/soc_bus_properties.sv */
`default_nettype none

module soc_bus_properties (
	input logic hdmi_pixClk,
	input logic rst_n,
	input logic cpu_req_valid,
	input logic cpu_req_ready,
	input logic cpu_rsp_valid,
	input logic gfx_req_valid,
	input logic gfx_req_ready,
	input logic gfx_rsp_valid
);

	int error_count = 0;

	// Each response belongs to the master accepted 3 cycles before
	one_owner: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(!cpu_rsp_valid || $past(cpu_req_valid && cpu_req_ready, 3)) &&
		(!gfx_rsp_valid || $past(gfx_req_valid && gfx_req_ready, 3)))
	else begin
		$error("Response returned to a master with no accepted request");
		error_count++;
	end

	// Response cycle may grant again
	no_ready_busy: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		((cpu_req_valid && cpu_req_ready) || (gfx_req_valid && gfx_req_ready))
			|=> !(cpu_req_ready || gfx_req_ready) ##1 !(cpu_req_ready || gfx_req_ready))
	else begin
		$error("req_ready high while a transaction is outstanding");
		error_count++;
	end

	cpu_latency: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(cpu_req_valid && cpu_req_ready) |-> ##3 cpu_rsp_valid)
	else begin
		$error("CPU response not 3 cycles after acceptance");
		error_count++;
	end

	gfx_latency: assert property (@(posedge hdmi_pixClk) disable iff (!rst_n)
		(gfx_req_valid && gfx_req_ready) |-> ##3 gfx_rsp_valid)
	else begin
		$error("Graphics response not 3 cycles after acceptance");
		error_count++;
	end

endmodule

bind bus_arbiter soc_bus_properties props (.*);

`default_nettype wire

/* dv/soc_bus_stimulus.txt */
// group master write addr wdata wstrb exp_rdata exp_err, hex; master 0 cpu, 1 gfx
// master 2 checks display outputs: addr column fb_base, wdata fb_stride, wstrb gfx_enable
00 0 1 02010000 11223344 f 00000000 0
01 0 0 02010000 00000000 0 11223344 0
02 0 1 02010000 aabbccdd 5 00000000 0
03 0 0 02010000 00000000 0 11bb33dd 0
04 1 1 02010004 cafef00d c 00000000 0
05 1 0 02010004 00000000 0 cafe0000 0
06 0 0 02000000 00000000 0 47580001 0
07 0 1 02000004 00000001 f 00000000 0
08 1 1 02000008 80000000 f 00000000 0
09 0 1 0200000c 12345678 f 00000000 0
0a 0 0 0200000c 00000000 0 00005678 0
0b 1 0 02000008 00000000 0 80000000 0
0c 1 1 02000000 ffffffff f 00000000 0 // ID is read only
0d 1 0 02000000 00000000 0 47580001 0
0e 0 1 80000000 deadbeef f 00000000 1 // Old SDRAM window
0f 0 0 80000000 00000000 0 00000000 1
10 1 0 03000000 00000000 0 00000000 1 // Old SD card window
11 1 1 03000000 deadbeef f 00000000 1
12 0 0 02010000 00000000 0 11bb33dd 0
12 1 0 02000008 00000000 0 80000000 0
13 0 1 02010008 01020304 f 00000000 0
14 0 0 02010008 00000000 0 01020304 0
14 1 1 02000004 00000003 1 00000000 0
15 2 0 80000000 00005678 1 00000000 0
16 0 1 0201000c 55667788 3 00000000 0
16 1 0 02010004 00000000 0 cafe0000 0
17 0 0 0201000c 00000000 0 00007788 0

/* dv/soc_bus_tb.sv */
`default_nettype none

module soc_bus_tb import soc_pkg::*; ();

	localparam int MAX_OPS = 64;

	logic hdmi_pixClk;
	logic rst_n;
	logic req_valid [2]; // Index 0 is the CPU port, 1 the graphics port
	logic req_ready [2];
	logic [ADDR_WIDTH-1:0] addr [2];
	logic write [2];
	logic [DATA_WIDTH-1:0] wdata [2];
	logic [STRB_WIDTH-1:0] wstrb [2];
	logic rsp_valid [2];
	logic [DATA_WIDTH-1:0] rdata [2];
	logic rsp_err [2];
	logic gfx_enable;
	logic [DATA_WIDTH-1:0] fb_base;
	logic [15:0] fb_stride;

	logic [31:0] stim [8*MAX_OPS]; // 8 columns per operation
	int num_ops;
	int cycle = 0;
	int limit = 0;
	int last_owner = M_GFX;

	tb_clock_gen clock_gen (.hdmi_pixClk(hdmi_pixClk), .rst_n(rst_n));

	soc_bus_top UUT (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.cpu_req_valid(req_valid[0]),
		.cpu_req_ready(req_ready[0]),
		.cpu_addr(addr[0]),
		.cpu_write(write[0]),
		.cpu_wdata(wdata[0]),
		.cpu_wstrb(wstrb[0]),
		.cpu_rsp_valid(rsp_valid[0]),
		.cpu_rdata(rdata[0]),
		.cpu_rsp_err(rsp_err[0]),
		.gfx_req_valid(req_valid[1]),
		.gfx_req_ready(req_ready[1]),
		.gfx_addr(addr[1]),
		.gfx_write(write[1]),
		.gfx_wdata(wdata[1]),
		.gfx_wstrb(wstrb[1]),
		.gfx_rsp_valid(rsp_valid[1]),
		.gfx_rdata(rdata[1]),
		.gfx_rsp_err(rsp_err[1]),
		.gfx_enable(gfx_enable),
		.fb_base(fb_base),
		.fb_stride(fb_stride)
	);

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_cond(input logic cond, input string what);
		assert (cond === 1'b1) else
			stop_on_error(what);
	endtask

	function automatic string op_name(input int i);
		return $sformatf("group %0h %s %s %h", stim[8*i], (stim[8*i+1] == 0) ? "cpu" : "gfx",
			stim[8*i+2][0] ? "write" : "read", stim[8*i+3]);
	endfunction

	always @(posedge hdmi_pixClk) begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit)
			stop_on_error($sformatf("Timeout after %0d cycles", cycle));
		if (UUT.arbiter.props.error_count != 0)
			stop_on_error("Bus handshake assertion failed");
	end

	// Issue ops first..last-1 together and follow them to their responses
	task automatic run_group(input int first, input int last);
		bit pend [2] = '{0, 0};
		bit waiting [2] = '{0, 0};
		int op [2];
		int acc [2];
		int m;
		int won;
		for (int i = first; i < last; i++) begin
			m = stim[8*i+1];
			op[m] = i;
			pend[m] = 1'b1;
			req_valid[m] <= 1'b1;
			addr[m] <= stim[8*i+3];
			write[m] <= stim[8*i+2][0];
			wdata[m] <= stim[8*i+4];
			wstrb[m] <= stim[8*i+5][STRB_WIDTH-1:0];
		end
		while (pend[0] || pend[1] || waiting[0] || waiting[1]) begin
			@(negedge hdmi_pixClk);
			for (int k = 0; k < 2; k++) begin
				if (rsp_valid[k]) begin
					check_cond(waiting[k], "Response to a master with no outstanding request");
					check_value({op_name(op[k]), " latency"}, 3, cycle - acc[k]);
					check_value({op_name(op[k]), " rdata"}, stim[8*op[k]+6], rdata[k]);
					check_value({op_name(op[k]), " err"}, stim[8*op[k]+7], rsp_err[k]);
					waiting[k] = 1'b0;
				end else if (waiting[k]) begin
					check_cond(!req_ready[0] && !req_ready[1],
						"req_ready high while a transaction is outstanding");
				end
			end
			won = -1;
			for (int k = 0; k < 2; k++) begin
				if (req_ready[k]) begin
					check_cond(pend[k], "req_ready given to a master without a request");
					won = k;
				end
			end
			if (won >= 0) begin
				check_cond(!(req_ready[0] && req_ready[1]), "Both masters granted at once");
				if (pend[0] && pend[1]) // Tie goes to the master not granted last
					check_value({op_name(op[won]), " grant"}, (last_owner == 0) ? 1 : 0, won);
				last_owner = won;
				pend[won] = 1'b0;
				waiting[won] = 1'b1;
				acc[won] = cycle;
			end
			@(posedge hdmi_pixClk);
			if (won >= 0)
				req_valid[won] <= 1'b0;
		end
	endtask

	task automatic check_outputs(input int i);
		@(negedge hdmi_pixClk);
		check_value("display fb_base", stim[8*i+3], fb_base);
		check_value("display fb_stride", stim[8*i+4], {16'h0000, fb_stride});
		check_value("display gfx_enable", stim[8*i+5], {31'd0, gfx_enable});
		@(posedge hdmi_pixClk);
	endtask

	initial begin
		int first;
		int next;
		void'($urandom(32'h2289));
		for (int k = 0; k < 2; k++) begin
			req_valid[k] <= 1'b0;
			addr[k] <= '0;
			write[k] <= 1'b0;
			wdata[k] <= '0;
			wstrb[k] <= '0;
		end
		for (int i = 0; i < 8*MAX_OPS; i++)
			stim[i] = '1; // All ones marks the end
		$readmemh("dv/soc_bus_stimulus.txt", stim);
		num_ops = 0;
		while (num_ops < MAX_OPS && stim[8*num_ops] != '1)
			num_ops++;
		limit = num_ops * 10 + 100;
		@(posedge hdmi_pixClk);
		while (!rst_n)
			@(posedge hdmi_pixClk);
		first = 0;
		while (first < num_ops) begin
			next = first;
			while (next < num_ops && stim[8*next] == stim[8*first])
				next++;
			if (stim[8*first+1] == 2)
				check_outputs(first);
			else
				run_group(first, next);
			repeat ($urandom % 4) @(posedge hdmi_pixClk);
			first = next;
		end
		if (UUT.arbiter.props.error_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
	output logic hdmi_pixClk,
	output logic rst_n
);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #4 hdmi_pixClk = ~hdmi_pixClk; // Period 8
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge hdmi_pixClk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module soc_bus_tb -f verilog.f
out=$(./obj_dir/Vsoc_bus_tb) || true
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"

/* src/addr_decoder.sv */
`default_nettype none

module addr_decoder import soc_pkg::*; (
	input  logic                   hdmi_pixClk,
	input  logic                   rst_n,

	input  logic                   bus_valid,
	input  logic [ADDR_WIDTH-1:0]  bus_addr,
	input  logic                   bus_write,
	input  logic [DATA_WIDTH-1:0]  bus_wdata,
	input  logic [STRB_WIDTH-1:0]  bus_wstrb,
	output logic                   bus_rsp_valid,
	output logic [DATA_WIDTH-1:0]  bus_rdata,
	output logic                   bus_err,

	output logic                   boot_sel,
	output logic                   gfx_sel,
	output logic                   slv_write,
	output logic [INDEX_WIDTH-1:0] slv_index,
	output logic [DATA_WIDTH-1:0]  slv_wdata,
	output logic [STRB_WIDTH-1:0]  slv_wstrb,
	input  logic [DATA_WIDTH-1:0]  boot_rdata,
	input  logic [DATA_WIDTH-1:0]  gfx_rdata
);

	logic [1:0] code;
	logic [1:0] pend_code; // Slave being accessed
	logic [1:0] data_code; // Slave whose rdata is now valid
	logic pend_valid;
	logic data_valid;

	always_comb begin
		if (bus_addr[ADDR_WIDTH-1:BOOT_ADDR_BITS] == BOOT_BASE[ADDR_WIDTH-1:BOOT_ADDR_BITS])
			code = S_BOOT;
		else if (bus_addr[ADDR_WIDTH-1:GFX_ADDR_BITS] == GFX_BASE[ADDR_WIDTH-1:GFX_ADDR_BITS])
			code = S_GFX;
		else
			code = S_NONE;
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			boot_sel <= 1'b0;
			gfx_sel <= 1'b0;
			pend_valid <= 1'b0;
			data_valid <= 1'b0;
			bus_rsp_valid <= 1'b0;
		end else begin
			boot_sel <= bus_valid && (code == S_BOOT);
			gfx_sel <= bus_valid && (code == S_GFX); // Unmapped writes touch nothing
			pend_valid <= bus_valid;
			data_valid <= pend_valid;
			bus_rsp_valid <= data_valid;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (bus_valid) begin
			pend_code <= code;
			slv_write <= bus_write;
			slv_index <= bus_addr[INDEX_WIDTH+1:2]; // Word address
			slv_wdata <= bus_wdata;
			slv_wstrb <= bus_wstrb;
		end
		data_code <= pend_code;
		if (data_valid) begin
			case (data_code)
				S_BOOT: begin
					bus_rdata <= boot_rdata;
					bus_err <= 1'b0;
				end
				S_GFX: begin
					bus_rdata <= gfx_rdata;
					bus_err <= 1'b0;
				end
				default: begin
					bus_rdata <= '0;
					bus_err <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/boot_ram.sv */
`default_nettype none

module boot_ram import soc_pkg::*; (
	input  logic                   hdmi_pixClk,
	input  logic                   sel,
	input  logic                   write,
	input  logic [INDEX_WIDTH-1:0] index,
	input  logic [DATA_WIDTH-1:0]  wdata,
	input  logic [STRB_WIDTH-1:0]  wstrb,
	output logic [DATA_WIDTH-1:0]  rdata
);

	logic [DATA_WIDTH-1:0] mem [BOOT_DEPTH];

	// Start from an empty memory
	initial begin
		for (int i = 0; i < BOOT_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (sel) begin
			if (write) begin
				for (int lane = 0; lane < STRB_WIDTH; lane++) begin
					if (wstrb[lane])
						mem[index][lane*8 +: 8] <= wdata[lane*8 +: 8];
				end
				rdata <= '0;
			end else begin
				rdata <= mem[index];
			end
		end
	end

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`default_nettype none

module bus_arbiter import soc_pkg::*; (
	input  logic                  hdmi_pixClk,
	input  logic                  rst_n,

	input  logic                  cpu_req_valid,
	output logic                  cpu_req_ready,
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  logic                  cpu_write,
	input  logic [DATA_WIDTH-1:0] cpu_wdata,
	input  logic [STRB_WIDTH-1:0] cpu_wstrb,
	output logic                  cpu_rsp_valid,
	output logic [DATA_WIDTH-1:0] cpu_rdata,
	output logic                  cpu_rsp_err,

	input  logic                  gfx_req_valid,
	output logic                  gfx_req_ready,
	input  logic [ADDR_WIDTH-1:0] gfx_addr,
	input  logic                  gfx_write,
	input  logic [DATA_WIDTH-1:0] gfx_wdata,
	input  logic [STRB_WIDTH-1:0] gfx_wstrb,
	output logic                  gfx_rsp_valid,
	output logic [DATA_WIDTH-1:0] gfx_rdata,
	output logic                  gfx_rsp_err,

	output logic                  bus_valid,
	output logic [ADDR_WIDTH-1:0] bus_addr,
	output logic                  bus_write,
	output logic [DATA_WIDTH-1:0] bus_wdata,
	output logic [STRB_WIDTH-1:0] bus_wstrb,
	input  logic                  bus_rsp_valid,
	input  logic [DATA_WIDTH-1:0] bus_rdata,
	input  logic                  bus_err
);

	logic busy;
	logic owner; // Master of the outstanding or last transaction
	logic idle;
	logic pick;

	// Free again in the response cycle
	assign idle = !busy || bus_rsp_valid;

	// Round robin on a tie
	always_comb begin
		if (cpu_req_valid && gfx_req_valid)
			pick = (owner == M_CPU) ? M_GFX : M_CPU;
		else if (cpu_req_valid)
			pick = M_CPU;
		else
			pick = M_GFX;
	end

	assign bus_valid = idle && (cpu_req_valid || gfx_req_valid);
	assign cpu_req_ready = bus_valid && (pick == M_CPU);
	assign gfx_req_ready = bus_valid && (pick == M_GFX);

	assign bus_addr  = (pick == M_CPU) ? cpu_addr  : gfx_addr;
	assign bus_write = (pick == M_CPU) ? cpu_write : gfx_write;
	assign bus_wdata = (pick == M_CPU) ? cpu_wdata : gfx_wdata;
	assign bus_wstrb = (pick == M_CPU) ? cpu_wstrb : gfx_wstrb;

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= M_GFX; // CPU wins the first tie
		end else if (bus_valid) begin
			busy <= 1'b1;
			owner <= pick;
		end else if (bus_rsp_valid) begin
			busy <= 1'b0;
		end
	end

	// Response goes back to its owner only
	assign cpu_rsp_valid = bus_rsp_valid && (owner == M_CPU);
	assign gfx_rsp_valid = bus_rsp_valid && (owner == M_GFX);
	assign cpu_rdata = cpu_rsp_valid ? bus_rdata : '0;
	assign gfx_rdata = gfx_rsp_valid ? bus_rdata : '0;
	assign cpu_rsp_err = cpu_rsp_valid && bus_err;
	assign gfx_rsp_err = gfx_rsp_valid && bus_err;

endmodule

`default_nettype wire

/* src/gfx_regs.sv */
`default_nettype none

module gfx_regs import soc_pkg::*; (
	input  logic                   hdmi_pixClk,
	input  logic                   rst_n,
	input  logic                   sel,
	input  logic                   write,
	input  logic [INDEX_WIDTH-1:0] index,
	input  logic [DATA_WIDTH-1:0]  wdata,
	input  logic [STRB_WIDTH-1:0]  wstrb,
	output logic [DATA_WIDTH-1:0]  rdata,
	output logic                   gfx_enable,
	output logic [DATA_WIDTH-1:0]  fb_base,
	output logic [15:0]            fb_stride
);

	logic [DATA_WIDTH-1:0] ctrl;
	logic hit;
	logic [DATA_WIDTH-1:0] rd_word;
	logic [DATA_WIDTH-1:0] stride_word;

	// Byte merge of a write into an old register value
	function automatic logic [DATA_WIDTH-1:0] merge(
		input logic [DATA_WIDTH-1:0] old,
		input logic [DATA_WIDTH-1:0] din,
		input logic [STRB_WIDTH-1:0] strb
	);
		logic [DATA_WIDTH-1:0] res;
		res = old;
		for (int lane = 0; lane < STRB_WIDTH; lane++) begin
			if (strb[lane])
				res[lane*8 +: 8] = din[lane*8 +: 8];
		end
		return res;
	endfunction

	// Only words 0 to 3 exist
	assign hit = (index[INDEX_WIDTH-1:2] == '0);

	assign stride_word = merge({16'h0000, fb_stride}, wdata, wstrb);

	always_comb begin
		case (index[1:0])
			2'd0: rd_word = GFX_ID;
			2'd1: rd_word = ctrl;
			2'd2: rd_word = fb_base;
			default: rd_word = {16'h0000, fb_stride};
		endcase
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (!rst_n) begin
			ctrl <= '0;
			fb_base <= '0;
			fb_stride <= '0;
		end else if (sel && write && hit) begin
			case (index[1:0])
				2'd1: ctrl <= merge(ctrl, wdata, wstrb);
				2'd2: fb_base <= merge(fb_base, wdata, wstrb);
				2'd3: fb_stride <= stride_word[15:0];
				default: ; // ID is read only
			endcase
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		if (sel)
			rdata <= (write || !hit) ? '0 : rd_word;
	end

	assign gfx_enable = ctrl[0];

endmodule

`default_nettype wire

/* src/soc_bus_top.sv */
`default_nettype none

module soc_bus_top import soc_pkg::*; (
	input  logic                  hdmi_pixClk,
	input  logic                  rst_n,

	input  logic                  cpu_req_valid,
	output logic                  cpu_req_ready,
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  logic                  cpu_write,
	input  logic [DATA_WIDTH-1:0] cpu_wdata,
	input  logic [STRB_WIDTH-1:0] cpu_wstrb,
	output logic                  cpu_rsp_valid,
	output logic [DATA_WIDTH-1:0] cpu_rdata,
	output logic                  cpu_rsp_err,

	input  logic                  gfx_req_valid,
	output logic                  gfx_req_ready,
	input  logic [ADDR_WIDTH-1:0] gfx_addr,
	input  logic                  gfx_write,
	input  logic [DATA_WIDTH-1:0] gfx_wdata,
	input  logic [STRB_WIDTH-1:0] gfx_wstrb,
	output logic                  gfx_rsp_valid,
	output logic [DATA_WIDTH-1:0] gfx_rdata,
	output logic                  gfx_rsp_err,

	output logic                  gfx_enable,
	output logic [DATA_WIDTH-1:0] fb_base,
	output logic [15:0]           fb_stride
);

	// Shared bus between arbiter and decoder
	logic                  bus_valid;
	logic [ADDR_WIDTH-1:0] bus_addr;
	logic                  bus_write;
	logic [DATA_WIDTH-1:0] bus_wdata;
	logic [STRB_WIDTH-1:0] bus_wstrb;
	logic                  bus_rsp_valid;
	logic [DATA_WIDTH-1:0] bus_rdata;
	logic                  bus_err;

	// Slave side
	logic                   boot_sel;
	logic                   gfx_sel;
	logic                   slv_write;
	logic [INDEX_WIDTH-1:0] slv_index;
	logic [DATA_WIDTH-1:0]  slv_wdata;
	logic [STRB_WIDTH-1:0]  slv_wstrb;
	logic [DATA_WIDTH-1:0]  boot_rdata;
	logic [DATA_WIDTH-1:0]  gfx_reg_rdata;

	bus_arbiter arbiter (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.cpu_req_valid(cpu_req_valid),
		.cpu_req_ready(cpu_req_ready),
		.cpu_addr(cpu_addr),
		.cpu_write(cpu_write),
		.cpu_wdata(cpu_wdata),
		.cpu_wstrb(cpu_wstrb),
		.cpu_rsp_valid(cpu_rsp_valid),
		.cpu_rdata(cpu_rdata),
		.cpu_rsp_err(cpu_rsp_err),
		.gfx_req_valid(gfx_req_valid),
		.gfx_req_ready(gfx_req_ready),
		.gfx_addr(gfx_addr),
		.gfx_write(gfx_write),
		.gfx_wdata(gfx_wdata),
		.gfx_wstrb(gfx_wstrb),
		.gfx_rsp_valid(gfx_rsp_valid),
		.gfx_rdata(gfx_rdata),
		.gfx_rsp_err(gfx_rsp_err),
		.bus_valid(bus_valid),
		.bus_addr(bus_addr),
		.bus_write(bus_write),
		.bus_wdata(bus_wdata),
		.bus_wstrb(bus_wstrb),
		.bus_rsp_valid(bus_rsp_valid),
		.bus_rdata(bus_rdata),
		.bus_err(bus_err)
	);

	addr_decoder decoder (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.bus_valid(bus_valid),
		.bus_addr(bus_addr),
		.bus_write(bus_write),
		.bus_wdata(bus_wdata),
		.bus_wstrb(bus_wstrb),
		.bus_rsp_valid(bus_rsp_valid),
		.bus_rdata(bus_rdata),
		.bus_err(bus_err),
		.boot_sel(boot_sel),
		.gfx_sel(gfx_sel),
		.slv_write(slv_write),
		.slv_index(slv_index),
		.slv_wdata(slv_wdata),
		.slv_wstrb(slv_wstrb),
		.boot_rdata(boot_rdata),
		.gfx_rdata(gfx_reg_rdata)
	);

	boot_ram bootloader (
		.hdmi_pixClk(hdmi_pixClk),
		.sel(boot_sel),
		.write(slv_write),
		.index(slv_index),
		.wdata(slv_wdata),
		.wstrb(slv_wstrb),
		.rdata(boot_rdata)
	);

	gfx_regs graphic_regs (
		.hdmi_pixClk(hdmi_pixClk),
		.rst_n(rst_n),
		.sel(gfx_sel),
		.write(slv_write),
		.index(slv_index),
		.wdata(slv_wdata),
		.wstrb(slv_wstrb),
		.rdata(gfx_reg_rdata),
		.gfx_enable(gfx_enable),
		.fb_base(fb_base),
		.fb_stride(fb_stride)
	);

endmodule

`default_nettype wire

/* src/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = 4;

	// Bootloader memory window
	localparam logic [ADDR_WIDTH-1:0] BOOT_BASE = 32'h0201_0000;
	localparam int BOOT_ADDR_BITS = 16;
	localparam int BOOT_DEPTH = 256; // Words

	// Graphics register window
	localparam logic [ADDR_WIDTH-1:0] GFX_BASE = 32'h0200_0000;
	localparam int GFX_ADDR_BITS = 8;
	localparam logic [DATA_WIDTH-1:0] GFX_ID = 32'h4758_0001;

	// Word index carried to the slaves, wide enough for the bootloader
	localparam int INDEX_WIDTH = $clog2(BOOT_DEPTH);

	// Master indices
	localparam logic M_CPU = 1'b0;
	localparam logic M_GFX = 1'b1;

	// Slave select codes
	localparam logic [1:0] S_NONE = 2'd0;
	localparam logic [1:0] S_BOOT = 2'd1;
	localparam logic [1:0] S_GFX = 2'd2;

endpackage

`default_nettype wire

/* verilog.f */
src/soc_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/boot_ram.sv
src/gfx_regs.sv
src/soc_bus_top.sv
dv/tb_clock_gen.sv
dv/soc_bus_properties.sv
dv/soc_bus_tb.sv
